//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - verilog/mips_decode_pkg.sv
      - verilog/instr_classify.sv
      - verilog/operand_select.sv
      - verilog/control_decode.sv
      - verilog/decode_register.sv
      - verilog/decode_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/decode_stage_tb.sv

//--- bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

//////////////////////////////
// Reference decode model
//////////////////////////////

localparam int REF_INVALID   = 0,
               REF_SHIFT_IMM = 1,
               REF_SHIFT_VAR = 2,
               REF_ALU_REG   = 3,
               REF_JR        = 4,
               REF_JALR      = 5,
               REF_LOAD      = 6,
               REF_STORE     = 7,
               REF_ALU_IMM   = 8,
               REF_LUI       = 9,
               REF_BEQ       = 10,
               REF_BNE       = 11,
               REF_JUMP      = 12;

function automatic int word_class(input logic [31:0] word);
   logic [5:0] opcode;
   logic [5:0] funct;
   opcode = word[31:26];
   funct  = word[5:0];
   if (opcode == 6'd0)
   begin
      case (funct)
         6'd0, 6'd2, 6'd3:                            return REF_SHIFT_IMM;
         6'd4, 6'd6, 6'd7:                            return REF_SHIFT_VAR;
         6'd33, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42: return REF_ALU_REG;
         6'd8:                                        return REF_JR;
         6'd9:                                        return REF_JALR;
         default:                                     return REF_INVALID;
      endcase
   end
   else
   begin
      case (opcode)
         6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd39: return REF_LOAD;
         6'd40, 6'd41, 6'd43:                      return REF_STORE;
         6'd8, 6'd10, 6'd12, 6'd13, 6'd14:         return REF_ALU_IMM;
         6'd15:                                    return REF_LUI;
         6'd4:                                     return REF_BEQ;
         6'd5:                                     return REF_BNE;
         6'd2, 6'd3:                               return REF_JUMP;
         default:                                  return REF_INVALID;
      endcase
   end
endfunction

// Packed as A, B, W, immediate, jump index
function automatic logic [56:0] operand_fields(input logic [31:0] word);
   logic [4:0]  reg_a;
   logic [4:0]  reg_b;
   logic [4:0]  reg_w;
   logic [15:0] imm;
   logic [25:0] index;
   reg_a = '0;
   reg_b = '0;
   reg_w = '0;
   imm   = '0;
   index = '0;
   case (word_class(word))
      REF_SHIFT_IMM:
      begin
         reg_a = word[20:16];
         reg_w = word[15:11];
         imm   = {11'd0, word[10:6]};                 // Shamt
      end
      REF_SHIFT_VAR:
      begin
         reg_a = word[20:16];
         reg_b = word[25:21];
         reg_w = word[15:11];
      end
      REF_ALU_REG:
      begin
         reg_a = word[25:21];
         reg_b = word[20:16];
         reg_w = word[15:11];
      end
      REF_JR:
         reg_a = word[25:21];
      REF_JALR:
      begin
         reg_a = word[25:21];
         reg_w = word[15:11];
      end
      REF_LOAD, REF_ALU_IMM:
      begin
         reg_a = word[25:21];
         reg_w = word[20:16];
         imm   = word[15:0];
      end
      REF_STORE, REF_BEQ, REF_BNE:
      begin
         reg_a = word[25:21];
         reg_b = word[20:16];                         // W stays zero for stores
         imm   = word[15:0];
      end
      REF_LUI:
      begin
         reg_w = word[20:16];
         imm   = word[15:0];
      end
      REF_JUMP:
         index = word[25:0];
      default:
         index = '0;
   endcase
   return {reg_a, reg_b, reg_w, imm, index};
endfunction

// RegDst RegWrite ALUSrc MemRead MemWrite MemtoReg, then ALUOp and branch flag
function automatic logic [10:0] control_levels(input logic [31:0] word);
   logic [5:0] levels;
   logic [1:0] alu_op;
   logic [2:0] flag;
   levels = 6'b000000;
   alu_op = 2'b00;
   flag   = 3'b000;
   case (word_class(word))
      REF_SHIFT_IMM, REF_SHIFT_VAR, REF_ALU_REG:
      begin
         levels = 6'b110000;
         alu_op = 2'b10;
      end
      REF_JR:
         flag = 3'b001;
      REF_JALR:
      begin
         levels = 6'b110000;
         flag   = 3'b010;
      end
      REF_LOAD:
         levels = 6'b011101;
      REF_STORE:
         levels = 6'b001010;
      REF_ALU_IMM, REF_LUI:
      begin
         levels = 6'b011000;
         alu_op = 2'b11;
      end
      REF_BEQ:
      begin
         alu_op = 2'b01;
         flag   = 3'b011;
      end
      REF_BNE:
      begin
         alu_op = 2'b01;
         flag   = 3'b100;
      end
      REF_JUMP:
         flag = 3'b101;
      default:
         flag = 3'b000;
   endcase
   return {levels, alu_op, flag};
endfunction

`endif

//--- bench/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb;

   localparam int NUM_INSTR     = 3000;
   localparam int RESET_CYCLES  = 16;
   localparam int DRAIN_TIMEOUT = 10;

   localparam logic [18:0][5:0] LISTED_OPCODES = {
      6'd2, 6'd3, 6'd4, 6'd5, 6'd8, 6'd10, 6'd12, 6'd13, 6'd14, 6'd15,
      6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd39, 6'd40, 6'd41, 6'd43};
   localparam logic [14:0][5:0] LISTED_FUNCTS = {
      6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd8, 6'd9,
      6'd33, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42};

   logic        i_clock;
   logic        i_soft_reset;
   logic [31:0] i_instruction;
   logic [4:0]  o_reg_a;
   logic [4:0]  o_reg_b;
   logic [4:0]  o_reg_w;
   logic [15:0] o_immediate;
   logic [25:0] o_jump_index;
   logic        o_reg_dst;
   logic        o_reg_write;
   logic        o_alu_src;
   logic        o_mem_read;
   logic        o_mem_write;
   logic        o_mem_to_reg;
   logic [1:0]  o_alu_op;
   logic [2:0]  o_branch_flag;

   integer      seed = 55589;
   logic [31:0] expected_q [$];
   logic [31:0] checked_word;                         // Instruction under check
   int          cycle;
   int          n;
   int          drain_cycles;

`include "decode_model.svh"

   decode_stage decode_stage_i
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_instruction (i_instruction),
      .o_reg_a       (o_reg_a),
      .o_reg_b       (o_reg_b),
      .o_reg_w       (o_reg_w),
      .o_immediate   (o_immediate),
      .o_jump_index  (o_jump_index),
      .o_reg_dst     (o_reg_dst),
      .o_reg_write   (o_reg_write),
      .o_alu_src     (o_alu_src),
      .o_mem_read    (o_mem_read),
      .o_mem_write   (o_mem_write),
      .o_mem_to_reg  (o_mem_to_reg),
      .o_alu_op      (o_alu_op),
      .o_branch_flag (o_branch_flag)
   );

   always #50 i_clock = ~i_clock;                     // 100 ns period

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "decode_stage_tb stopped at the first error");
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string name);
      if (actual !== expected)
      begin
         $display("Mismatch at %0d ns: %s is %h, expected %h, instruction %h",
                  $time, name, actual, expected, checked_word);
         abort_run();
      end
   endtask

   task automatic check_reset_state();
      checked_word = '0;
      check_value({o_reg_a, o_reg_b, o_reg_w, o_immediate}, '0, "register fields in reset");
      check_value(o_jump_index, '0, "o_jump_index in reset");
      check_value({o_reg_dst, o_reg_write, o_alu_src, o_mem_read, o_mem_write,
                   o_mem_to_reg, o_alu_op, o_branch_flag}, '0, "control levels in reset");
   endtask

   task automatic check_oldest();
      logic [56:0] fields;
      logic [10:0] controls;
      if (expected_q.size() == 0)
      begin
         $display("Error: output checked with no instruction pending");
         abort_run();
      end
      checked_word = expected_q.pop_front();
      fields       = operand_fields(checked_word);
      controls     = control_levels(checked_word);
      check_value(o_reg_a, fields[56:52], "o_reg_a");
      check_value(o_reg_b, fields[51:47], "o_reg_b");
      check_value(o_reg_w, fields[46:42], "o_reg_w");
      check_value(o_immediate, fields[41:26], "o_immediate");
      check_value(o_jump_index, fields[25:0], "o_jump_index");
      check_value(o_reg_dst, controls[10], "o_reg_dst");
      check_value(o_reg_write, controls[9], "o_reg_write");
      check_value(o_alu_src, controls[8], "o_alu_src");
      check_value(o_mem_read, controls[7], "o_mem_read");
      check_value(o_mem_write, controls[6], "o_mem_write");
      check_value(o_mem_to_reg, controls[5], "o_mem_to_reg");
      check_value(o_alu_op, controls[4:3], "o_alu_op");
      check_value(o_branch_flag, controls[2:0], "o_branch_flag");
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   // Three words in four carry a listed opcode or function code
   task automatic drive_word();
      logic [31:0] word;
      word = $random(seed);
      if (($random(seed) & 3) != 0)
      begin
         if (($random(seed) & 1) != 0)
            word[31:26] = LISTED_OPCODES[$unsigned($random(seed)) % 19];
         else
         begin
            word[31:26] = 6'd0;                       // SPECIAL
            word[5:0]   = LISTED_FUNCTS[$unsigned($random(seed)) % 15];
         end
      end
      i_instruction = word;
   endtask

   initial
   begin
      i_clock       = 1'b0;
      i_soft_reset  = 1'b0;
      i_instruction = '0;
      for (cycle = 0; cycle < RESET_CYCLES - 1; cycle++)
      begin
         @(negedge i_clock);
         check_reset_state();
         drive_word();                                // Ignored while in reset
      end
      for (n = 0; n < NUM_INSTR; n++)
      begin
         @(negedge i_clock);
         if (n == 0)
         begin
            check_reset_state();                      // Last reset edge still clear
            i_soft_reset = 1'b1;
         end
         else
            check_oldest();
         drive_word();
         expected_q.push_back(i_instruction);
      end
      drain_cycles = 0;
      while (expected_q.size() != 0 && drain_cycles < DRAIN_TIMEOUT)
      begin
         @(negedge i_clock);
         check_oldest();
         drain_cycles++;
      end
      if (expected_q.size() != 0)
      begin
         $display("Error: expected queue did not drain");
         abort_run();
      end
      else
      begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

//--- build.f
+incdir+bench
verilog/mips_decode_pkg.sv
verilog/instr_classify.sv
verilog/operand_select.sv
verilog/control_decode.sv
verilog/decode_register.sv
verilog/decode_stage.sv
bench/decode_stage_tb.sv

//--- verilog/control_decode.sv
`timescale 1ns/100ps

module control_decode
(
   input  mips_decode_pkg::instr_class_e i_class,
   output logic                          o_reg_dst,
   output logic                          o_reg_write,
   output logic                          o_alu_src,
   output logic                          o_mem_read,
   output logic                          o_mem_write,
   output logic                          o_mem_to_reg,
   output mips_decode_pkg::alu_op_e      o_alu_op,
   output mips_decode_pkg::branch_flag_e o_branch_flag
);

   import mips_decode_pkg::*;

   always_comb
   begin
      o_reg_dst     = 1'b0;
      o_reg_write   = 1'b0;
      o_alu_src     = 1'b0;
      o_mem_read    = 1'b0;
      o_mem_write   = 1'b0;
      o_mem_to_reg  = 1'b0;
      o_alu_op      = ALU_OP_ADD;
      o_branch_flag = BRANCH_NONE;
      case (i_class)
         CLASS_SHIFT_IMM, CLASS_SHIFT_VAR, CLASS_ALU_REG:
         begin
            o_reg_dst   = 1'b1;
            o_reg_write = 1'b1;
            o_alu_op    = ALU_OP_FUNCT;
         end
         CLASS_JR:
            o_branch_flag = BRANCH_JR;
         CLASS_JALR:
         begin
            o_reg_dst     = 1'b1;
            o_reg_write   = 1'b1;
            o_branch_flag = BRANCH_JALR;
         end
         CLASS_LOAD:
         begin
            o_reg_write  = 1'b1;
            o_alu_src    = 1'b1;                 // Base plus offset
            o_mem_read   = 1'b1;
            o_mem_to_reg = 1'b1;
         end
         CLASS_STORE:
         begin
            o_alu_src   = 1'b1;
            o_mem_write = 1'b1;
         end
         CLASS_ALU_IMM, CLASS_LUI:
         begin
            o_reg_write = 1'b1;
            o_alu_src   = 1'b1;
            o_alu_op    = ALU_OP_IMM;
         end
         CLASS_BEQ:
         begin
            o_alu_op      = ALU_OP_BRANCH;
            o_branch_flag = BRANCH_BEQ;
         end
         CLASS_BNE:
         begin
            o_alu_op      = ALU_OP_BRANCH;
            o_branch_flag = BRANCH_BNE;
         end
         CLASS_JUMP:
            o_branch_flag = BRANCH_JUMP;
         default:
            o_branch_flag = BRANCH_NONE;         // Invalid drives nothing
      endcase
   end

   always_comb
   begin
      assert final (!(o_mem_read && o_mem_write))
         else $error("control_decode: memory read and write together");
      assert final (!o_mem_to_reg || o_mem_read)
         else $error("control_decode: MemtoReg without MemRead");
   end

endmodule

//--- verilog/decode_register.sv
`timescale 1ns/100ps

module decode_register
#(
   parameter int REG_ADDR_WIDTH = mips_decode_pkg::REG_ADDR_WIDTH,
   parameter int IMM_WIDTH      = mips_decode_pkg::IMM_WIDTH
)
(
   input  logic                                         i_clock,
   input  logic                                         i_soft_reset,
   input  logic [REG_ADDR_WIDTH-1:0]                    i_reg_a,
   input  logic [REG_ADDR_WIDTH-1:0]                    i_reg_b,
   input  logic [REG_ADDR_WIDTH-1:0]                    i_reg_w,
   input  logic [IMM_WIDTH-1:0]                         i_immediate,
   input  logic [mips_decode_pkg::JUMP_INDEX_WIDTH-1:0] i_jump_index,
   input  logic                                         i_reg_dst,
   input  logic                                         i_reg_write,
   input  logic                                         i_alu_src,
   input  logic                                         i_mem_read,
   input  logic                                         i_mem_write,
   input  logic                                         i_mem_to_reg,
   input  mips_decode_pkg::alu_op_e                     i_alu_op,
   input  mips_decode_pkg::branch_flag_e                i_branch_flag,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_a,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_b,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_w,
   output logic [IMM_WIDTH-1:0]                         o_immediate,
   output logic [mips_decode_pkg::JUMP_INDEX_WIDTH-1:0] o_jump_index,
   output logic                                         o_reg_dst,
   output logic                                         o_reg_write,
   output logic                                         o_alu_src,
   output logic                                         o_mem_read,
   output logic                                         o_mem_write,
   output logic                                         o_mem_to_reg,
   output mips_decode_pkg::alu_op_e                     o_alu_op,
   output mips_decode_pkg::branch_flag_e                o_branch_flag
);

   import mips_decode_pkg::*;

   always_ff @(posedge i_clock)
   begin
      if (!i_soft_reset)
      begin
         o_reg_a       <= '0;
         o_reg_b       <= '0;
         o_reg_w       <= '0;
         o_immediate   <= '0;
         o_jump_index  <= '0;
         o_reg_dst     <= 1'b0;
         o_reg_write   <= 1'b0;
         o_alu_src     <= 1'b0;
         o_mem_read    <= 1'b0;
         o_mem_write   <= 1'b0;
         o_mem_to_reg  <= 1'b0;
         o_alu_op      <= ALU_OP_ADD;
         o_branch_flag <= BRANCH_NONE;
      end
      else
      begin
         o_reg_a       <= i_reg_a;
         o_reg_b       <= i_reg_b;
         o_reg_w       <= i_reg_w;
         o_immediate   <= i_immediate;
         o_jump_index  <= i_jump_index;
         o_reg_dst     <= i_reg_dst;
         o_reg_write   <= i_reg_write;
         o_alu_src     <= i_alu_src;
         o_mem_read    <= i_mem_read;
         o_mem_write   <= i_mem_write;
         o_mem_to_reg  <= i_mem_to_reg;
         o_alu_op      <= i_alu_op;
         o_branch_flag <= i_branch_flag;
      end
   end

   // No register or memory write may leak out of a reset cycle
   a_reset_quiet : assert property (
      @(posedge i_clock) !i_soft_reset |=> (!o_reg_write && !o_mem_write))
      else $error("decode_register: write strobe set after reset");

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
#(
   parameter int REG_ADDR_WIDTH = mips_decode_pkg::REG_ADDR_WIDTH,
   parameter int IMM_WIDTH      = mips_decode_pkg::IMM_WIDTH
)
(
   input  logic                                         i_clock,
   input  logic                                         i_soft_reset,
   input  logic [mips_decode_pkg::INSTR_WIDTH-1:0]      i_instruction,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_a,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_b,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_w,
   output logic [IMM_WIDTH-1:0]                         o_immediate,
   output logic [mips_decode_pkg::JUMP_INDEX_WIDTH-1:0] o_jump_index,
   output logic                                         o_reg_dst,
   output logic                                         o_reg_write,
   output logic                                         o_alu_src,
   output logic                                         o_mem_read,
   output logic                                         o_mem_write,
   output logic                                         o_mem_to_reg,
   output mips_decode_pkg::alu_op_e                     o_alu_op,
   output mips_decode_pkg::branch_flag_e                o_branch_flag
);

   import mips_decode_pkg::*;

   instr_class_e                w_class;
   logic [REG_ADDR_WIDTH-1:0]   w_reg_a;
   logic [REG_ADDR_WIDTH-1:0]   w_reg_b;
   logic [REG_ADDR_WIDTH-1:0]   w_reg_w;
   logic [IMM_WIDTH-1:0]        w_immediate;
   logic [JUMP_INDEX_WIDTH-1:0] w_jump_index;
   logic                        w_reg_dst;
   logic                        w_reg_write;
   logic                        w_alu_src;
   logic                        w_mem_read;
   logic                        w_mem_write;
   logic                        w_mem_to_reg;
   alu_op_e                     w_alu_op;
   branch_flag_e                w_branch_flag;

   //////////////////////////////
   // Combinational decode
   //////////////////////////////

   instr_classify instr_classify_i
   (
      .i_instruction (i_instruction),
      .o_class       (w_class)
   );

   operand_select
   #(
      .REG_ADDR_WIDTH (REG_ADDR_WIDTH),
      .IMM_WIDTH      (IMM_WIDTH)
   )
   operand_select_i
   (
      .i_instruction (i_instruction),
      .i_class       (w_class),
      .o_reg_a       (w_reg_a),
      .o_reg_b       (w_reg_b),
      .o_reg_w       (w_reg_w),
      .o_immediate   (w_immediate),
      .o_jump_index  (w_jump_index)
   );

   control_decode control_decode_i
   (
      .i_class       (w_class),
      .o_reg_dst     (w_reg_dst),
      .o_reg_write   (w_reg_write),
      .o_alu_src     (w_alu_src),
      .o_mem_read    (w_mem_read),
      .o_mem_write   (w_mem_write),
      .o_mem_to_reg  (w_mem_to_reg),
      .o_alu_op      (w_alu_op),
      .o_branch_flag (w_branch_flag)
   );

   //////////////////////////////
   // Output register
   //////////////////////////////

   decode_register
   #(
      .REG_ADDR_WIDTH (REG_ADDR_WIDTH),
      .IMM_WIDTH      (IMM_WIDTH)
   )
   decode_register_i
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_reg_a       (w_reg_a),
      .i_reg_b       (w_reg_b),
      .i_reg_w       (w_reg_w),
      .i_immediate   (w_immediate),
      .i_jump_index  (w_jump_index),
      .i_reg_dst     (w_reg_dst),
      .i_reg_write   (w_reg_write),
      .i_alu_src     (w_alu_src),
      .i_mem_read    (w_mem_read),
      .i_mem_write   (w_mem_write),
      .i_mem_to_reg  (w_mem_to_reg),
      .i_alu_op      (w_alu_op),
      .i_branch_flag (w_branch_flag),
      .o_reg_a       (o_reg_a),
      .o_reg_b       (o_reg_b),
      .o_reg_w       (o_reg_w),
      .o_immediate   (o_immediate),
      .o_jump_index  (o_jump_index),
      .o_reg_dst     (o_reg_dst),
      .o_reg_write   (o_reg_write),
      .o_alu_src     (o_alu_src),
      .o_mem_read    (o_mem_read),
      .o_mem_write   (o_mem_write),
      .o_mem_to_reg  (o_mem_to_reg),
      .o_alu_op      (o_alu_op),
      .o_branch_flag (o_branch_flag)
   );

endmodule

//--- verilog/instr_classify.sv
`timescale 1ns/100ps

module instr_classify
(
   input  logic [mips_decode_pkg::INSTR_WIDTH-1:0] i_instruction,
   output mips_decode_pkg::instr_class_e           o_class
);

   import mips_decode_pkg::*;

   localparam int OPCODE_LSB = INSTR_WIDTH - FIELD_WIDTH;

   logic [FIELD_WIDTH-1:0] w_opcode;
   logic [FIELD_WIDTH-1:0] w_funct;

   assign w_opcode = i_instruction[OPCODE_LSB +: FIELD_WIDTH];   // Bits 31:26
   assign w_funct  = i_instruction[FIELD_WIDTH-1:0];             // Bits 5:0

   //////////////////////////////
   // Opcode and function decode
   //////////////////////////////

   always_comb
   begin
      o_class = CLASS_INVALID;
      if (w_opcode == OP_SPECIAL)
      begin
         case (w_funct)
            FN_SLL, FN_SRL, FN_SRA:
               o_class = CLASS_SHIFT_IMM;
            FN_SLLV, FN_SRLV, FN_SRAV:
               o_class = CLASS_SHIFT_VAR;
            FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT:
               o_class = CLASS_ALU_REG;
            FN_JR:
               o_class = CLASS_JR;
            FN_JALR:
               o_class = CLASS_JALR;
            default:
               o_class = CLASS_INVALID;
         endcase
      end
      else
      begin
         case (w_opcode)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU:
               o_class = CLASS_LOAD;
            OP_SB, OP_SH, OP_SW:
               o_class = CLASS_STORE;
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI:
               o_class = CLASS_ALU_IMM;
            OP_LUI:
               o_class = CLASS_LUI;
            OP_BEQ:
               o_class = CLASS_BEQ;
            OP_BNE:
               o_class = CLASS_BNE;
            OP_J, OP_JAL:
               o_class = CLASS_JUMP;   // JAL writes no link register
            default:
               o_class = CLASS_INVALID;
         endcase
      end
   end

   // Known instruction must never leave the class unresolved
   always_comb
   begin
      if (!$isunknown(i_instruction))
      begin
         assert final (!$isunknown(o_class))
            else $error("instr_classify: unknown class for known instruction");
      end
   end

endmodule

//--- verilog/mips_decode_pkg.sv
package mips_decode_pkg;

   //////////////////////////////
   // Field widths
   //////////////////////////////

   localparam int INSTR_WIDTH      = 32;
   localparam int REG_ADDR_WIDTH   = 5;
   localparam int IMM_WIDTH        = 16;
   localparam int JUMP_INDEX_WIDTH = 26;
   localparam int FIELD_WIDTH      = 6;    // Opcode and function field

   //////////////////////////////
   // Encodings
   //////////////////////////////

   typedef enum logic [FIELD_WIDTH-1:0]
   {
      OP_SPECIAL = 6'd0,                   // Decoded by function field
      OP_J       = 6'd2,
      OP_JAL     = 6'd3,
      OP_BEQ     = 6'd4,
      OP_BNE     = 6'd5,
      OP_ADDI    = 6'd8,
      OP_SLTI    = 6'd10,
      OP_ANDI    = 6'd12,
      OP_ORI     = 6'd13,
      OP_XORI    = 6'd14,
      OP_LUI     = 6'd15,
      OP_LB      = 6'd32,
      OP_LH      = 6'd33,
      OP_LW      = 6'd35,
      OP_LBU     = 6'd36,
      OP_LHU     = 6'd37,
      OP_LWU     = 6'd39,
      OP_SB      = 6'd40,
      OP_SH      = 6'd41,
      OP_SW      = 6'd43
   } opcode_e;

   typedef enum logic [FIELD_WIDTH-1:0]
   {
      FN_SLL  = 6'd0,
      FN_SRL  = 6'd2,
      FN_SRA  = 6'd3,
      FN_SLLV = 6'd4,
      FN_SRLV = 6'd6,
      FN_SRAV = 6'd7,
      FN_JR   = 6'd8,
      FN_JALR = 6'd9,
      FN_ADDU = 6'd33,
      FN_SUBU = 6'd35,
      FN_AND  = 6'd36,
      FN_OR   = 6'd37,
      FN_XOR  = 6'd38,
      FN_NOR  = 6'd39,
      FN_SLT  = 6'd42
   } funct_e;

   typedef enum logic [3:0]
   {
      CLASS_INVALID = 4'd0,                // Unlisted opcode or function
      CLASS_SHIFT_IMM,
      CLASS_SHIFT_VAR,
      CLASS_ALU_REG,
      CLASS_JR,
      CLASS_JALR,
      CLASS_LOAD,
      CLASS_STORE,
      CLASS_ALU_IMM,
      CLASS_LUI,
      CLASS_BEQ,
      CLASS_BNE,
      CLASS_JUMP                           // J and JAL alike
   } instr_class_e;

   typedef enum logic [2:0]
   {
      BRANCH_NONE = 3'b000,
      BRANCH_JR   = 3'b001,
      BRANCH_JALR = 3'b010,
      BRANCH_BEQ  = 3'b011,
      BRANCH_BNE  = 3'b100,
      BRANCH_JUMP = 3'b101
   } branch_flag_e;

   typedef enum logic [1:0]
   {
      ALU_OP_ADD    = 2'b00,               // Address and link arithmetic
      ALU_OP_BRANCH = 2'b01,
      ALU_OP_FUNCT  = 2'b10,               // ALU looks at function field
      ALU_OP_IMM    = 2'b11
   } alu_op_e;

endpackage

//--- verilog/operand_select.sv
`timescale 1ns/100ps

module operand_select
#(
   parameter int REG_ADDR_WIDTH = mips_decode_pkg::REG_ADDR_WIDTH,
   parameter int IMM_WIDTH      = mips_decode_pkg::IMM_WIDTH
)
(
   input  logic [mips_decode_pkg::INSTR_WIDTH-1:0]      i_instruction,
   input  mips_decode_pkg::instr_class_e                i_class,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_a,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_b,
   output logic [REG_ADDR_WIDTH-1:0]                    o_reg_w,
   output logic [IMM_WIDTH-1:0]                         o_immediate,
   output logic [mips_decode_pkg::JUMP_INDEX_WIDTH-1:0] o_jump_index
);

   import mips_decode_pkg::*;

   localparam int RS_LSB      = 21;
   localparam int RT_LSB      = 16;
   localparam int RD_LSB      = 11;
   localparam int SHAMT_LSB   = 6;
   localparam int SHAMT_WIDTH = 5;

   logic [REG_ADDR_WIDTH-1:0]   w_rs;
   logic [REG_ADDR_WIDTH-1:0]   w_rt;
   logic [REG_ADDR_WIDTH-1:0]   w_rd;
   logic [SHAMT_WIDTH-1:0]      w_shamt;
   logic [IMM_WIDTH-1:0]        w_imm;
   logic [JUMP_INDEX_WIDTH-1:0] w_index;

   // Narrow register files keep the low address bits
   assign w_rs    = i_instruction[RS_LSB +: REG_ADDR_WIDTH];
   assign w_rt    = i_instruction[RT_LSB +: REG_ADDR_WIDTH];
   assign w_rd    = i_instruction[RD_LSB +: REG_ADDR_WIDTH];
   assign w_shamt = i_instruction[SHAMT_LSB +: SHAMT_WIDTH];
   assign w_imm   = i_instruction[IMM_WIDTH-1:0];
   assign w_index = i_instruction[JUMP_INDEX_WIDTH-1:0];

   always_comb
   begin
      o_reg_a      = '0;
      o_reg_b      = '0;
      o_reg_w      = '0;
      o_immediate  = '0;
      o_jump_index = '0;
      case (i_class)
         CLASS_SHIFT_IMM:
         begin
            o_reg_a     = w_rt;
            o_reg_w     = w_rd;
            o_immediate = IMM_WIDTH'(w_shamt);   // Zero extended shamt
         end
         CLASS_SHIFT_VAR:
         begin
            o_reg_a = w_rt;
            o_reg_b = w_rs;                      // Shift amount register
            o_reg_w = w_rd;
         end
         CLASS_ALU_REG:
         begin
            o_reg_a = w_rs;
            o_reg_b = w_rt;
            o_reg_w = w_rd;
         end
         CLASS_JR:
            o_reg_a = w_rs;
         CLASS_JALR:
         begin
            o_reg_a = w_rs;
            o_reg_w = w_rd;                      // Link register
         end
         CLASS_LOAD, CLASS_ALU_IMM:
         begin
            o_reg_a     = w_rs;
            o_reg_w     = w_rt;
            o_immediate = w_imm;
         end
         CLASS_STORE, CLASS_BEQ, CLASS_BNE:
         begin
            o_reg_a     = w_rs;
            o_reg_b     = w_rt;                  // Store data or compare operand
            o_immediate = w_imm;
         end
         CLASS_LUI:
         begin
            o_reg_w     = w_rt;
            o_immediate = w_imm;
         end
         CLASS_JUMP:
            o_jump_index = w_index;
         default:
            o_reg_a = '0;                        // Invalid stays all zero
      endcase
   end

endmodule
